// ==== design/sdramArray.sv ====
`default_nettype none

module sdramArray #(
    parameter int RowBits = 4,
    parameter int ColBits = 6
) (
    input  logic                              Clk,
    input  logic [sdramPkg::BankBits-1:0]     memBank,
    input  logic [RowBits+ColBits-1:0]        memIndex,
    input  logic [1:0]                        memWe,
    input  logic [sdramPkg::DataBits-1:0]     memWrData,
    output logic [sdramPkg::DataBits-1:0]     rdData
);

    localparam int NumBanks = 2 ** sdramPkg::BankBits;
    localparam int Words    = 2 ** (RowBits + ColBits);

    logic [sdramPkg::DataBits-1:0] mem [NumBanks][Words];

    // Asynchronous read of the addressed word
    assign rdData = mem[memBank][memIndex];

    // Byte lane writes
    always_ff @(posedge Clk) begin
        for (int b = 0; b < 2; b++) begin
            if (memWe[b]) begin
                mem[memBank][memIndex][b*8 +: 8] <= memWrData[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/sdramBurstEngine.sv ====
`default_nettype none

module sdramBurstEngine #(
    parameter int RowBits = 4,
    parameter int ColBits = 6
) (
    input  logic                              Clk,
    input  logic                              arstN,
    input  sdramPkg::sdramMode_t              mode,
    input  sdramPkg::colAccess_t              head,
    input  logic [1:0]                        Dqm,
    input  logic [sdramPkg::DataBits-1:0]     DqIn,
    input  logic [sdramPkg::DataBits-1:0]     rdData,
    output logic [sdramPkg::BankBits-1:0]     memBank,
    output logic [RowBits+ColBits-1:0]        memIndex,
    output logic [1:0]                        memWe,
    output logic [sdramPkg::DataBits-1:0]     memWrData,
    output logic [sdramPkg::DataBits-1:0]     DqOut,
    output logic [1:0]                        DqOe
);

    logic                          active;
    logic                          burstWrite;
    logic [2:0]                    beatCnt;
    logic [1:0]                    dqmD1;
    logic [sdramPkg::BankBits-1:0] burstBank;
    logic [RowBits-1:0]            burstRow;
    logic [ColBits-1:0]            burstStart;

    logic                          beatValid;
    logic                          curIsWrite;
    logic [2:0]                    curBeat;
    logic [ColBits-1:0]            curStart;
    logic [RowBits-1:0]            curRow;
    logic [2:0]                    lenMask;
    logic [2:0]                    seqLow;
    logic [2:0]                    colLow;

    // Burst length code to wrap mask, also the last beat index
    always_comb begin
        case (mode.burstLen)
            3'd1:    lenMask = 3'b001;
            3'd2:    lenMask = 3'b011;
            3'd3:    lenMask = 3'b111;
            default: lenMask = 3'b000;
        endcase
    end

    // A fresh head access is beat 0 and overrides the running burst
    always_comb begin
        beatValid  = head.valid || active;
        curIsWrite = head.valid ? head.isWrite : burstWrite;
        curBeat    = head.valid ? 3'd0 : beatCnt + 3'd1;
        curStart   = head.valid ? head.col[ColBits-1:0] : burstStart;
        curRow     = head.valid ? head.row[RowBits-1:0] : burstRow;
        memBank    = head.valid ? head.bank : burstBank;
    end

    // Column order within the burst-aligned block
    always_comb begin
        seqLow = curStart[2:0] + curBeat;
        if (mode.interleave) begin
            colLow = curStart[2:0] ^ curBeat;
        end else begin
            colLow = (seqLow & lenMask) | (curStart[2:0] & ~lenMask);
        end
    end

    assign memIndex  = {curRow, curStart[ColBits-1:3], colLow};
    assign memWrData = DqIn;
    // Write DQM applies in the same cycle
    assign memWe     = (beatValid && curIsWrite) ? ~Dqm : 2'b00;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            active     <= 1'b0;
            burstWrite <= 1'b0;
            beatCnt    <= '0;
            dqmD1      <= '0;
            DqOe       <= '0;
        end else begin
            dqmD1 <= Dqm;
            // Second DQM stage; lane enable follows the mask from one edge back
            DqOe  <= (beatValid && !curIsWrite) ? ~dqmD1 : 2'b00;
            if (head.valid) begin
                active     <= (lenMask != 3'd0);
                burstWrite <= head.isWrite;
                beatCnt    <= 3'd0;
            end else if (active) begin
                active  <= (curBeat != lenMask);
                beatCnt <= curBeat;
            end
        end
    end

    // Burst address and read data
    always_ff @(posedge Clk) begin
        if (head.valid) begin
            burstBank  <= head.bank;
            burstRow   <= head.row[RowBits-1:0];
            burstStart <= head.col[ColBits-1:0];
        end
        if (beatValid && !curIsWrite) begin
            DqOut <= rdData;
        end
    end

    // No lane is driven while a write beat is on the bus
    assert property (@(posedge Clk) disable iff (!arstN)
        (beatValid && curIsWrite) |-> (DqOe == 2'b00));

endmodule

`default_nettype wire

// ==== design/sdramCasPipe.sv ====
`default_nettype none

module sdramCasPipe (
    input  logic                 Clk,
    input  logic                 arstN,
    input  sdramPkg::sdramMode_t mode,
    input  sdramPkg::colAccess_t acc,
    output sdramPkg::colAccess_t head
);

    localparam int Depth = sdramPkg::ClMax - 1;

    sdramPkg::colAccess_t stage [Depth];
    logic                 readIn;

    assign readIn = acc.valid && !acc.isWrite;

    // Stage 0 feeds head; a read enters CL-2 stages from head
    for (genvar i = 0; i < Depth; i++) begin : gStage
        sdramPkg::colAccess_t upstream;

        if (i == Depth - 1) begin : gLast
            assign upstream = '0;
        end else begin : gMid
            assign upstream = stage[i + 1];

            // Two reads never fall due at head in the same cycle
            assert property (@(posedge Clk) disable iff (!arstN)
                (readIn && (mode.casLat == 3'(i + 2))) |-> !upstream.valid);
        end

        always_ff @(posedge Clk or negedge arstN) begin
            if (!arstN) begin
                stage[i] <= '0;
            end else if (readIn && (mode.casLat == 3'(i + 2))) begin
                stage[i] <= acc;
            end else begin
                stage[i] <= upstream;
            end
        end
    end

    // Writes bypass the pipe and win over a read due the same cycle
    always_comb begin
        if (acc.valid && acc.isWrite) begin
            head = acc;
        end else begin
            head = stage[0];
        end
    end

endmodule

`default_nettype wire

// ==== design/sdramCmdDecode.sv ====
`default_nettype none

module sdramCmdDecode #(
    parameter int RowBits = 4
) (
    input  logic                              Clk,
    input  logic                              arstN,
    input  logic                              CsN,
    input  logic                              RasN,
    input  logic                              CasN,
    input  logic                              WeN,
    input  sdramPkg::addrWord_u               Addr,
    input  logic [sdramPkg::BankBits-1:0]     Ba,
    output sdramPkg::sdramMode_t              mode,
    output sdramPkg::colAccess_t              acc
);

    localparam int NumBanks = 2 ** sdramPkg::BankBits;

    sdramPkg::cmd_e       cmd;
    logic [NumBanks-1:0]  bankOpen;
    logic [RowBits-1:0]   rowLatch [NumBanks];

    // Pin decode, Cs Ras Cas We all active low
    always_comb begin
        case ({CsN, RasN, CasN, WeN})
            4'b0011: cmd = sdramPkg::CmdActive;
            4'b0101: cmd = sdramPkg::CmdRead;
            4'b0100: cmd = sdramPkg::CmdWrite;
            4'b0010: cmd = sdramPkg::CmdPrecharge;
            4'b0000: cmd = sdramPkg::CmdLoadMode;
            default: cmd = sdramPkg::CmdNop;
        endcase
    end

    // Mode register and bank open flags
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            mode.burstLen   <= 3'd0;
            mode.interleave <= 1'b0;
            mode.casLat     <= 3'd2;
            bankOpen        <= '0;
        end else begin
            case (cmd)
                sdramPkg::CmdLoadMode: begin
                    mode.burstLen   <= Addr.modeView.burstLen;
                    mode.interleave <= Addr.modeView.interleave;
                    mode.casLat     <= Addr.modeView.casLat;
                end
                sdramPkg::CmdActive: begin
                    bankOpen[Ba] <= 1'b1;
                end
                sdramPkg::CmdPrecharge: begin
                    // A10 high closes every bank
                    if (Addr.colView.a10) begin
                        bankOpen <= '0;
                    end else begin
                        bankOpen[Ba] <= 1'b0;
                    end
                end
                default: begin
                    bankOpen <= bankOpen;
                end
            endcase
        end
    end

    // Row captured at activate
    always_ff @(posedge Clk) begin
        if (cmd == sdramPkg::CmdActive) begin
            rowLatch[Ba] <= Addr.rowView[RowBits-1:0];
        end
    end

    // Column access leaves in the command cycle itself
    always_comb begin
        acc.valid   = (cmd == sdramPkg::CmdRead) || (cmd == sdramPkg::CmdWrite);
        acc.isWrite = (cmd == sdramPkg::CmdWrite);
        acc.bank    = Ba;
        acc.row     = {{(sdramPkg::AddrBits - RowBits){1'b0}}, rowLatch[Ba]};
        acc.col     = Addr.colView.col;
    end

    // Column commands need a bank opened by an earlier ACTIVE
    assert property (@(posedge Clk) disable iff (!arstN)
        (cmd inside {sdramPkg::CmdRead, sdramPkg::CmdWrite}) |-> bankOpen[Ba]);

    // Mode load only with all banks idle
    assert property (@(posedge Clk) disable iff (!arstN)
        (cmd == sdramPkg::CmdLoadMode) |-> (bankOpen == '0));

    // The loaded mode must be one this device supports
    assert property (@(posedge Clk) disable iff (!arstN)
        (cmd == sdramPkg::CmdLoadMode) |=>
            ((mode.burstLen <= 3'd3) && (mode.casLat inside {3'd2, 3'd3})));

endmodule

`default_nettype wire

// ==== design/sdramPkg.sv ====
`default_nettype none

package sdramPkg;

    // Device pin widths
    localparam int AddrBits = 13;
    localparam int DataBits = 16;
    localparam int BankBits = 2;
    localparam int ColPins  = 10;

    // Deepest supported CAS latency
    localparam int ClMax = 3;

    // Commands after pin decode; refresh and burst stop fall to Nop
    typedef enum logic [2:0] {
        CmdNop       = 3'd0,
        CmdActive    = 3'd1,
        CmdRead      = 3'd2,
        CmdWrite     = 3'd3,
        CmdPrecharge = 3'd4,
        CmdLoadMode  = 3'd5
    } cmd_e;

    // Addr during READ, WRITE and PRECHARGE
    typedef struct packed {
        logic [AddrBits-ColPins-2:0] rsvd;
        logic                        a10;
        logic [ColPins-1:0]          col;
    } colView_t;

    // Addr during LOAD MODE
    typedef struct packed {
        logic [AddrBits-8:0] rsvd;
        logic [2:0]          casLat;
        logic                interleave;
        logic [2:0]          burstLen;
    } modeView_t;

    // One address word, read differently per command
    typedef union packed {
        logic [AddrBits-1:0] rowView;
        colView_t            colView;
        modeView_t           modeView;
    } addrWord_u;

    // Held mode register
    typedef struct packed {
        logic [2:0] burstLen;
        logic       interleave;
        logic [2:0] casLat;
    } sdramMode_t;

    // One column access on its way to the burst engine
    typedef struct packed {
        logic                valid;
        logic                isWrite;
        logic [BankBits-1:0] bank;
        logic [AddrBits-1:0] row;
        logic [ColPins-1:0]  col;
    } colAccess_t;

endpackage

`default_nettype wire

// ==== design/sdramTop.sv ====
`default_nettype none

module sdramTop #(
    parameter int RowBits = 4,
    parameter int ColBits = 6
) (
    input  logic                              Clk,
    input  logic                              arstN,
    input  logic                              CsN,
    input  logic                              RasN,
    input  logic                              CasN,
    input  logic                              WeN,
    input  logic [sdramPkg::AddrBits-1:0]     Addr,
    input  logic [sdramPkg::BankBits-1:0]     Ba,
    input  logic [1:0]                        Dqm,
    input  logic [sdramPkg::DataBits-1:0]     DqIn,
    output logic [sdramPkg::DataBits-1:0]     DqOut,
    output logic [1:0]                        DqOe
);

    sdramPkg::addrWord_u           addrWord;
    sdramPkg::sdramMode_t          mode;
    sdramPkg::colAccess_t          acc;
    sdramPkg::colAccess_t          head;
    logic [sdramPkg::BankBits-1:0] memBank;
    logic [RowBits+ColBits-1:0]    memIndex;
    logic [1:0]                    memWe;
    logic [sdramPkg::DataBits-1:0] memWrData;
    logic [sdramPkg::DataBits-1:0] rdData;

    assign addrWord = Addr;

    sdramCmdDecode #(
        .RowBits (RowBits)
    ) i_cmdDecode (
        .Clk   (Clk),
        .arstN (arstN),
        .CsN   (CsN),
        .RasN  (RasN),
        .CasN  (CasN),
        .WeN   (WeN),
        .Addr  (addrWord),
        .Ba    (Ba),
        .mode  (mode),
        .acc   (acc)
    );

    // Read accesses wait here for the CAS latency
    sdramCasPipe i_casPipe (
        .Clk   (Clk),
        .arstN (arstN),
        .mode  (mode),
        .acc   (acc),
        .head  (head)
    );

    sdramBurstEngine #(
        .RowBits (RowBits),
        .ColBits (ColBits)
    ) i_burstEngine (
        .Clk       (Clk),
        .arstN     (arstN),
        .mode      (mode),
        .head      (head),
        .Dqm       (Dqm),
        .DqIn      (DqIn),
        .rdData    (rdData),
        .memBank   (memBank),
        .memIndex  (memIndex),
        .memWe     (memWe),
        .memWrData (memWrData),
        .DqOut     (DqOut),
        .DqOe      (DqOe)
    );

    sdramArray #(
        .RowBits (RowBits),
        .ColBits (ColBits)
    ) i_array (
        .Clk       (Clk),
        .memBank   (memBank),
        .memIndex  (memIndex),
        .memWe     (memWe),
        .memWrData (memWrData),
        .rdData    (rdData)
    );

endmodule

`default_nettype wire

// ==== files.f ====
design/sdramPkg.sv
design/sdramCmdDecode.sv
design/sdramCasPipe.sv
design/sdramBurstEngine.sv
design/sdramArray.sv
design/sdramTop.sv
test/sdramRefModel.sv
test/sdramTb.sv

// ==== test/sdramRefModel.sv ====
`default_nettype none

module sdramRefModel #(
    parameter int RowBits = 4,
    parameter int ColBits = 6
);

    logic [2:0]         burstLen;
    logic               interleave;
    logic [2:0]         casLat;
    logic [RowBits-1:0] openRow [4];
    logic [15:0]        mem [int];

    // Mode after reset
    initial begin
        burstLen   = 3'd0;
        interleave = 1'b0;
        casLat     = 3'd2;
    end

    task automatic setMode(input logic [2:0] bl, input logic il, input logic [2:0] cl);
        burstLen   = bl;
        interleave = il;
        casLat     = cl;
    endtask

    task automatic activate(input int bank, input int row);
        openRow[bank] = row[RowBits-1:0];
    endtask

    function automatic int beatCount();
        return 1 << burstLen;
    endfunction

    // Column of beat k; sequential order wraps inside the aligned block
    function automatic int beatCol(input int startCol, input int k);
        int mask;
        mask = beatCount() - 1;
        if (interleave) begin
            return startCol ^ k;
        end
        return (startCol & ~mask) | ((startCol + k) & mask);
    endfunction

    function automatic int wordKey(input int bank, input int col);
        return (bank << (RowBits + ColBits)) | (int'(openRow[bank]) << ColBits) | col;
    endfunction

    // Masked lanes keep whatever the word held before
    task automatic writeWord(input int bank, input int col, input logic [15:0] data,
                             input logic [1:0] dqm);
        int          key;
        logic [15:0] word;
        key  = wordKey(bank, col);
        word = mem.exists(key) ? mem[key] : 16'hxxxx;
        for (int b = 0; b < 2; b++) begin
            if (!dqm[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        mem[key] = word;
    endtask

    // Unknown bytes mark words never written
    function automatic logic [15:0] readWord(input int bank, input int col);
        int key;
        key = wordKey(bank, col);
        if (mem.exists(key)) begin
            return mem[key];
        end
        return 16'hxxxx;
    endfunction

endmodule

`default_nettype wire

// ==== test/sdramTb.sv ====
`default_nettype none

module sdramTb;

    localparam int RowBits = 4;
    localparam int ColBits = 6;
    localparam int Timeout = 30;

    // Cs Ras Cas We, all active low
    localparam logic [3:0] PinsNop       = 4'b0111;
    localparam logic [3:0] PinsActive    = 4'b0011;
    localparam logic [3:0] PinsRead      = 4'b0101;
    localparam logic [3:0] PinsWrite     = 4'b0100;
    localparam logic [3:0] PinsPrecharge = 4'b0010;
    localparam logic [3:0] PinsLoadMode  = 4'b0000;

    logic        Clk;
    logic        arstN;
    logic        CsN;
    logic        RasN;
    logic        CasN;
    logic        WeN;
    logic [12:0] Addr;
    logic [1:0]  Ba;
    logic [1:0]  Dqm;
    logic [15:0] DqIn;
    logic [15:0] DqOut;
    logic [1:0]  DqOe;

    int          seed;
    int          cyc;
    int          errors;
    int          timeouts;
    // Expected read word per edge that registers it
    logic [15:0] expDq [int];
    logic [1:0]  dqmHist [int];

    sdramTop #(
        .RowBits (RowBits),
        .ColBits (ColBits)
    ) i_dut (
        .Clk   (Clk),
        .arstN (arstN),
        .CsN   (CsN),
        .RasN  (RasN),
        .CasN  (CasN),
        .WeN   (WeN),
        .Addr  (Addr),
        .Ba    (Ba),
        .Dqm   (Dqm),
        .DqIn  (DqIn),
        .DqOut (DqOut),
        .DqOe  (DqOe)
    );

    sdramRefModel #(
        .RowBits (RowBits),
        .ColBits (ColBits)
    ) i_refModel ();

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    initial begin
        #(100 * 10000);
        $display("Watchdog expired before the test sequence completed");
        $display("Simulation FAILED");
        $finish;
    end

    // One edge, then compare what the DUT registered there
    task automatic tick();
        logic [1:0] oeExp;
        logic [7:0] laneExp;
        @(posedge Clk);
        cyc++;
        dqmHist[cyc] = Dqm;
        #10;
        oeExp = expDq.exists(cyc) ? ~dqmHist[cyc - 1] : 2'b00;
        assert (DqOe === oeExp) else begin
            errors++;
            $display("ERR %0t: DqOe is %b, expected %b", $time, DqOe, oeExp);
        end
        for (int b = 0; b < 2; b++) begin
            if (oeExp[b]) begin
                laneExp = expDq[cyc][b*8 +: 8];
                if (!$isunknown(laneExp)) begin
                    assert (DqOut[b*8 +: 8] === laneExp) else begin
                        errors++;
                        $display("ERR %0t: DqOut lane %0d is %h, expected %h",
                                 $time, b, DqOut[b*8 +: 8], laneExp);
                    end
                end
            end
        end
    endtask

    task automatic step();
        Dqm  = 2'($random(seed));
        DqIn = 16'($random(seed));
        tick();
    endtask

    task automatic issue(input logic [3:0] pins, input logic [1:0] bank, input logic [12:0] a);
        {CsN, RasN, CasN, WeN} = pins;
        Ba   = bank;
        Addr = a;
        step();
        {CsN, RasN, CasN, WeN} = PinsNop;
    endtask

    // Beat k is stored at the k-th edge after the command edge
    task automatic writeBurst(input logic [1:0] bank, input int col);
        for (int k = 0; k < i_refModel.beatCount(); k++) begin
            if (k == 0) begin
                {CsN, RasN, CasN, WeN} = PinsWrite;
                Ba   = bank;
                Addr = {3'b000, 10'(col)};
            end
            Dqm  = 2'($random(seed));
            DqIn = 16'($random(seed));
            i_refModel.writeWord(bank, i_refModel.beatCol(col, k), DqIn, Dqm);
            tick();
            {CsN, RasN, CasN, WeN} = PinsNop;
        end
    endtask

    task automatic readBurst(input logic [1:0] bank, input int col);
        int first;
        first = cyc + i_refModel.casLat;
        // Beats of an older burst from this edge on never come
        for (int c = first; c < first + 12; c++) begin
            if (expDq.exists(c)) begin
                expDq.delete(c);
            end
        end
        for (int k = 0; k < i_refModel.beatCount(); k++) begin
            expDq[first + k] = i_refModel.readWord(bank, i_refModel.beatCol(col, k));
        end
        issue(PinsRead, bank, {3'b000, 10'(col)});
    endtask

    function automatic bit beatsPending();
        for (int c = cyc + 1; c <= cyc + 12; c++) begin
            if (expDq.exists(c)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic drain();
        int t;
        t = 0;
        while ((beatsPending() || DqOe !== 2'b00) && t < Timeout) begin
            step();
            t++;
        end
        if (t >= Timeout) begin
            timeouts++;
            $display("Read burst still running after %0d cycles at time %0t", Timeout, $time);
        end
    endtask

    initial begin
        int bank;
        int col;
        int row;
        int gap;
        seed     = 32'h445d_f6f1;
        cyc      = 0;
        errors   = 0;
        timeouts = 0;
        arstN    = 1'b0;
        {CsN, RasN, CasN, WeN} = PinsNop;
        Addr     = '0;
        Ba       = '0;
        Dqm      = '0;
        DqIn     = '0;
        repeat (10) tick();
        arstN = 1'b1;
        // Every burst length, order and CAS latency
        for (int cfg = 0; cfg < 16; cfg++) begin
            issue(PinsPrecharge, 2'd0, 13'h0400);
            issue(PinsLoadMode, 2'd0, {6'd0, 3'(2 + cfg[3]), cfg[2], 1'b0, cfg[1:0]});
            i_refModel.setMode({1'b0, cfg[1:0]}, cfg[2], 3'(2 + cfg[3]));
            for (int b = 0; b < 4; b++) begin
                row = $random(seed) & 3;
                issue(PinsActive, 2'(b), 13'(row));
                i_refModel.activate(b, row);
            end
            repeat (12) begin
                bank = $random(seed) & 3;
                col  = $random(seed) & 15;
                if ($random(seed) & 1) begin
                    writeBurst(2'(bank), col);
                end else begin
                    readBurst(2'(bank), col);
                    // Sometimes a second read cuts the first one short
                    if (($random(seed) & 3) == 0) begin
                        gap = $random(seed) & 3;
                        repeat (gap) step();
                        readBurst(2'($random(seed)), $random(seed) & 15);
                    end
                end
                drain();
            end
        end
        $display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
